// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  --top-module dcache_tb -f flist.f

run: compile
	./obj_dir/Vdcache_tb +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
hw/dcache_pkg.sv
hw/dcache_way_if.sv
hw/dcache_way.sv
hw/dcache_plru.sv
hw/dcache_select.sv
hw/dcache.sv
verification/dcache_sva.sv
verification/dcache_tb.sv

// ==== hw/dcache.sv ====
// data cache top level: four ways, pseudo-LRU and output select

`timescale 1ns/1ns

module dcache (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [dcache_pkg::ADDR_BITS-1:0]  rd_addr,
  input  logic                              rd_search,
  input  logic                              wr_en,
  input  logic                              wr_from_mem,
  input  logic                              wr_search,
  input  logic [dcache_pkg::ADDR_BITS-1:0]  wr_addr,
  input  logic [dcache_pkg::LINE_BITS-1:0]  wr_data,
  input  logic                              wr_valid,
  input  logic                              wr_dirty,
  output logic                              rd_hit,
  output logic [dcache_pkg::LINE_BITS-1:0]  rd_data,
  output logic                              wr_hit,
  output logic                              evicted_valid,
  output logic                              evicted_dirty,
  output logic [dcache_pkg::ADDR_BITS-1:0]  evicted_addr,
  output logic [dcache_pkg::LINE_BITS-1:0]  evicted_data
);

  import dcache_pkg::*;

  // decoded write address, the LRU needs its set index
  dcache_addr_u wr_word;

  logic [NUM_WAYS-1:0] way_wr_en;
  logic [NUM_WAYS-1:0] victim_sel;
  logic [WAY_BITS-1:0] victim_way;
  logic                fill;

  dcache_way_if way_bus [NUM_WAYS] ();

  assign wr_word = wr_addr;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    dcache_way i_way (
      .clock    (clock),
      .reset    (reset),
      .wr_en    (way_wr_en[w]),
      .rd_addr  (rd_addr),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_valid (wr_valid),
      .wr_dirty (wr_dirty),
      .lookup   (way_bus[w])
    );
  end

  dcache_plru i_plru (
    .clock      (clock),
    .reset      (reset),
    .fill       (fill),
    .set_index  (wr_word.fields.set_index),
    .victim_sel (victim_sel),
    .victim_way (victim_way)
  );

  dcache_select i_select (
    .wr_en         (wr_en),
    .wr_from_mem   (wr_from_mem),
    .rd_search     (rd_search),
    .wr_search     (wr_search),
    .wr_addr       (wr_word),
    .victim_sel    (victim_sel),
    .victim_way    (victim_way),
    .ways          (way_bus),
    .way_wr_en     (way_wr_en),
    .fill          (fill),
    .rd_hit        (rd_hit),
    .rd_data       (rd_data),
    .wr_hit        (wr_hit),
    .evicted_valid (evicted_valid),
    .evicted_dirty (evicted_dirty),
    .evicted_addr  (evicted_addr),
    .evicted_data  (evicted_data)
  );

endmodule

// ==== hw/dcache_pkg.sv ====
// data cache constants, address union and cache line struct

package dcache_pkg;

  // geometry
  localparam integer NUM_WAYS = 4;
  localparam integer NUM_SETS = 16;
  localparam integer WAY_BITS = $clog2(NUM_WAYS);

  // address split, 25 + 4 + 3 bits
  localparam integer ADDR_BITS   = 32;
  localparam integer SET_BITS    = 4;
  localparam integer OFFSET_BITS = 3;
  localparam integer TAG_BITS    = 25;

  // one line is a single 64-bit word
  localparam integer LINE_BITS = 64;

  // decoded view of an address word
  typedef struct packed {
    logic [TAG_BITS-1:0]    tag;
    logic [SET_BITS-1:0]    set_index;
    logic [OFFSET_BITS-1:0] offset;
  } dcache_addr_fields_t;

  // same 32 bits, seen flat at the ports or split into fields
  typedef union packed {
    logic [ADDR_BITS-1:0] raw;
    dcache_addr_fields_t  fields;
  } dcache_addr_u;

  // one stored line, 91 bits
  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [TAG_BITS-1:0]  tag;
    logic [LINE_BITS-1:0] data;
  } dcache_line_t;

endpackage

// ==== hw/dcache_plru.sv ====
// tree pseudo-LRU state per set, one-hot victim and encoded victim way

`timescale 1ns/1ns

module dcache_plru (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               fill,
  input  logic [dcache_pkg::SET_BITS-1:0]    set_index,
  output logic [dcache_pkg::NUM_WAYS-1:0]    victim_sel,
  output logic [dcache_pkg::WAY_BITS-1:0]    victim_way
);

  import dcache_pkg::*;

  // tree bits, one of each per set
  // a picks the half, b picks within ways 0/1, c within ways 2/3
  logic [NUM_SETS-1:0] tree_a;
  logic [NUM_SETS-1:0] tree_b;
  logic [NUM_SETS-1:0] tree_c;

  // bits of the set being written
  logic cur_a;
  logic cur_b;
  logic cur_c;

  assign cur_a = tree_a[set_index];
  assign cur_b = tree_b[set_index];
  assign cur_c = tree_c[set_index];

  // one-hot victim from the tree walk
  assign victim_sel[0] = !cur_a && !cur_b;
  assign victim_sel[1] = !cur_a &&  cur_b;
  assign victim_sel[2] =  cur_a && !cur_c;
  assign victim_sel[3] =  cur_a &&  cur_c;

  // one-hot to way number
  always_comb begin
    victim_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (victim_sel[w]) begin
        victim_way = victim_way | w[WAY_BITS-1:0];
      end
    end
  end

  // only fills move the tree, hits leave it alone
  always_ff @(posedge clock) begin
    if (reset) begin
      tree_a <= '0;
      tree_b <= '0;
      tree_c <= '0;
    end else if (fill) begin
      tree_a[set_index] <= ~cur_a;
      // flip the side that was just used
      if (!cur_a) begin
        tree_b[set_index] <= ~cur_b;
      end else begin
        tree_c[set_index] <= ~cur_c;
      end
    end
  end

endmodule

// ==== hw/dcache_select.sv ====
// hit merge, read data mux, write enable steering and victim output mux

`timescale 1ns/1ns

module dcache_select (
  input  logic                              wr_en,
  input  logic                              wr_from_mem,
  input  logic                              rd_search,
  input  logic                              wr_search,
  input  dcache_pkg::dcache_addr_u          wr_addr,
  input  logic [dcache_pkg::NUM_WAYS-1:0]   victim_sel,
  input  logic [dcache_pkg::WAY_BITS-1:0]   victim_way,
  dcache_way_if.sel                         ways [dcache_pkg::NUM_WAYS],
  output logic [dcache_pkg::NUM_WAYS-1:0]   way_wr_en,
  output logic                              fill,
  output logic                              rd_hit,
  output logic [dcache_pkg::LINE_BITS-1:0]  rd_data,
  output logic                              wr_hit,
  output logic                              evicted_valid,
  output logic                              evicted_dirty,
  output dcache_pkg::dcache_addr_u          evicted_addr,
  output logic [dcache_pkg::LINE_BITS-1:0]  evicted_data
);

  import dcache_pkg::*;

  // per-way signals gathered into indexable arrays
  logic [NUM_WAYS-1:0]  rd_hits;
  logic [NUM_WAYS-1:0]  wr_hits;
  logic [NUM_WAYS-1:0]  vic_valids;
  logic [NUM_WAYS-1:0]  vic_dirtys;
  logic [LINE_BITS-1:0] rd_datas  [NUM_WAYS];
  logic [TAG_BITS-1:0]  vic_tags  [NUM_WAYS];
  logic [LINE_BITS-1:0] vic_datas [NUM_WAYS];

  logic wr_hit_any;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_gather
    assign rd_hits[w]    = ways[w].rd_hit;
    assign wr_hits[w]    = ways[w].wr_hit;
    assign rd_datas[w]   = ways[w].rd_data;
    assign vic_valids[w] = ways[w].victim_valid;
    assign vic_dirtys[w] = ways[w].victim_dirty;
    assign vic_tags[w]   = ways[w].victim_tag;
    assign vic_datas[w]  = ways[w].victim_data;
  end

  // read port, data is zero unless a searched way hits
  always_comb begin
    rd_hit  = 1'b0;
    rd_data = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (rd_hits[w] && rd_search) begin
        rd_hit  = 1'b1;
        rd_data = rd_datas[w];
      end
    end
  end

  // raw write hit steers, reported hit needs the search strobe
  assign wr_hit_any = |wr_hits;
  assign wr_hit     = wr_hit_any && wr_search;

  // store hits go to the hitting way, fills that miss go to the victim
  assign fill = wr_en && wr_from_mem && !wr_hit_any;

  always_comb begin
    way_wr_en = '0;
    if (wr_en && wr_hit_any) begin
      way_wr_en = wr_hits;
    end else if (fill) begin
      way_wr_en = victim_sel;
    end
  end

  // victim fields, address rebuilt at line granularity
  always_comb begin
    evicted_valid                 = vic_valids[victim_way];
    evicted_dirty                 = vic_dirtys[victim_way];
    evicted_data                  = vic_datas[victim_way];
    evicted_addr.fields.tag       = vic_tags[victim_way];
    evicted_addr.fields.set_index = wr_addr.fields.set_index;
    evicted_addr.fields.offset    = '0;
  end

endmodule

// ==== hw/dcache_way.sv ====
// one cache way: line storage for all sets, tag compare, victim candidate

`timescale 1ns/1ns

module dcache_way (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              wr_en,
  input  dcache_pkg::dcache_addr_u          rd_addr,
  input  dcache_pkg::dcache_addr_u          wr_addr,
  input  logic [dcache_pkg::LINE_BITS-1:0]  wr_data,
  input  logic                              wr_valid,
  input  logic                              wr_dirty,
  dcache_way_if.way                         lookup
);

  import dcache_pkg::*;

  dcache_line_t lines [NUM_SETS];

  // lines addressed by each port
  dcache_line_t rd_line;
  dcache_line_t wr_line;

  assign rd_line = lines[rd_addr.fields.set_index];
  assign wr_line = lines[wr_addr.fields.set_index];

  // read side tag compare
  assign lookup.rd_hit  = rd_line.valid && (rd_line.tag == rd_addr.fields.tag);
  assign lookup.rd_data = rd_line.data;

  // write side tag compare, used to steer stores
  assign lookup.wr_hit = wr_line.valid && (wr_line.tag == wr_addr.fields.tag);

  // whatever sits at the write set is the candidate for eviction
  assign lookup.victim_valid = wr_line.valid;
  assign lookup.victim_dirty = wr_line.dirty;
  assign lookup.victim_tag   = wr_line.tag;
  assign lookup.victim_data  = wr_line.data;

  // only valid and dirty are cleared, tag and data keep their contents
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        lines[s].valid <= 1'b0;
        lines[s].dirty <= 1'b0;
      end
    end else if (wr_en) begin
      lines[wr_addr.fields.set_index] <= '{
        valid: wr_valid,
        dirty: wr_dirty,
        tag:   wr_addr.fields.tag,
        data:  wr_data
      };
    end
  end

endmodule

// ==== hw/dcache_way_if.sv ====
// interface carrying one way's lookup results and victim candidate

`timescale 1ns/1ns

interface dcache_way_if;

  import dcache_pkg::*;

  // lookup results
  logic                 rd_hit;
  logic [LINE_BITS-1:0] rd_data;
  logic                 wr_hit;

  // line currently held at the write set
  logic                 victim_valid;
  logic                 victim_dirty;
  logic [TAG_BITS-1:0]  victim_tag;
  logic [LINE_BITS-1:0] victim_data;

  modport way (
    output rd_hit, rd_data, wr_hit,
    output victim_valid, victim_dirty, victim_tag, victim_data
  );

  modport sel (
    input rd_hit, rd_data, wr_hit,
    input victim_valid, victim_dirty, victim_tag, victim_data
  );

endinterface

// ==== verification/dcache_sva.sv ====
// bound checks on the data cache ports: reset state, fill visibility, search gating

`timescale 1ns/1ns

module dcache_sva (
  input logic                              clock,
  input logic                              reset,
  input logic [dcache_pkg::ADDR_BITS-1:0]  rd_addr,
  input logic                              rd_search,
  input logic                              wr_en,
  input logic                              wr_from_mem,
  input logic                              wr_search,
  input logic [dcache_pkg::ADDR_BITS-1:0]  wr_addr,
  input logic [dcache_pkg::LINE_BITS-1:0]  wr_data,
  input logic                              wr_valid,
  input logic                              rd_hit,
  input logic [dcache_pkg::LINE_BITS-1:0]  rd_data,
  input logic                              wr_hit,
  input logic                              evicted_valid
);

  import dcache_pkg::*;

  // one failure count per assertion
  int reset_fails   = 0;
  int fill_fails    = 0;
  int rd_gate_fails = 0;
  int wr_gate_fails = 0;
  int failures;

  assign failures = reset_fails + fill_fails + rd_gate_fails + wr_gate_fails;

  // a reset edge empties every set
  a_reset_clears: assert property (@(posedge clock)
    reset |=> (!rd_hit && !wr_hit && !evicted_valid))
    else begin
      $error("cache outputs not clear after a reset cycle");
      reset_fails++;
    end

  // a valid line written from memory is readable in the next cycle
  a_fill_then_read: assert property (@(posedge clock) disable iff (reset)
    ($past(wr_en && wr_from_mem && wr_valid) && rd_search &&
     rd_addr[ADDR_BITS-1:OFFSET_BITS] == $past(wr_addr[ADDR_BITS-1:OFFSET_BITS]))
    |-> (rd_hit && rd_data == $past(wr_data)))
    else begin
      $error("line written from memory not returned by the next read");
      fill_fails++;
    end

  a_rd_gate: assert property (@(posedge clock) disable iff (reset)
    !rd_search |-> !rd_hit)
    else begin
      $error("rd_hit high while rd_search is low");
      rd_gate_fails++;
    end

  a_wr_gate: assert property (@(posedge clock) disable iff (reset)
    !wr_search |-> !wr_hit)
    else begin
      $error("wr_hit high while wr_search is low");
      wr_gate_fails++;
    end

endmodule

bind dcache dcache_sva i_sva (
  .clock         (clock),
  .reset         (reset),
  .rd_addr       (rd_addr),
  .rd_search     (rd_search),
  .wr_en         (wr_en),
  .wr_from_mem   (wr_from_mem),
  .wr_search     (wr_search),
  .wr_addr       (wr_addr),
  .wr_data       (wr_data),
  .wr_valid      (wr_valid),
  .rd_hit        (rd_hit),
  .rd_data       (rd_data),
  .wr_hit        (wr_hit),
  .evicted_valid (evicted_valid)
);

// ==== verification/dcache_tb.sv ====
// data cache testbench: clock, reset, reference model, directed and random traffic

`timescale 1ns/1ns

module dcache_tb;

  import dcache_pkg::*;

  logic                 clock;
  logic                 reset;
  logic [ADDR_BITS-1:0] rd_addr;
  logic                 rd_search;
  logic                 wr_en;
  logic                 wr_from_mem;
  logic                 wr_search;
  logic [ADDR_BITS-1:0] wr_addr;
  logic [LINE_BITS-1:0] wr_data;
  logic                 wr_valid;
  logic                 wr_dirty;
  logic                 rd_hit;
  logic [LINE_BITS-1:0] rd_data;
  logic                 wr_hit;
  logic                 evicted_valid;
  logic                 evicted_dirty;
  logic [ADDR_BITS-1:0] evicted_addr;
  logic [LINE_BITS-1:0] evicted_data;

  integer seed;
  int     errors;

  // expected line state per set and way
  logic [TAG_BITS-1:0]  m_tag   [NUM_SETS][NUM_WAYS];
  logic [LINE_BITS-1:0] m_data  [NUM_SETS][NUM_WAYS];
  logic                 m_valid [NUM_SETS][NUM_WAYS];
  logic                 m_dirty [NUM_SETS][NUM_WAYS];
  // tree bits per set
  logic                 m_a     [NUM_SETS];
  logic                 m_b     [NUM_SETS];
  logic                 m_c     [NUM_SETS];

  dcache i_dut (
    .clock         (clock),
    .reset         (reset),
    .rd_addr       (rd_addr),
    .rd_search     (rd_search),
    .wr_en         (wr_en),
    .wr_from_mem   (wr_from_mem),
    .wr_search     (wr_search),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_valid      (wr_valid),
    .wr_dirty      (wr_dirty),
    .rd_hit        (rd_hit),
    .rd_data       (rd_data),
    .wr_hit        (wr_hit),
    .evicted_valid (evicted_valid),
    .evicted_dirty (evicted_dirty),
    .evicted_addr  (evicted_addr),
    .evicted_data  (evicted_data)
  );

  always #4 clock = ~clock;

  function automatic logic [TAG_BITS-1:0] tag_of(input logic [ADDR_BITS-1:0] addr);
    return addr[ADDR_BITS-1 -: TAG_BITS];
  endfunction

  function automatic logic [SET_BITS-1:0] set_of(input logic [ADDR_BITS-1:0] addr);
    return addr[OFFSET_BITS +: SET_BITS];
  endfunction

  function automatic logic [ADDR_BITS-1:0] line_addr(input logic [TAG_BITS-1:0] tag,
                                                     input logic [SET_BITS-1:0] set);
    return {tag, set, {OFFSET_BITS{1'b0}}};
  endfunction

  // eight tags over sets 0 to 3 with any offset
  function automatic logic [ADDR_BITS-1:0] small_addr(input logic [7:0] bits);
    return {{(TAG_BITS-3){1'b0}}, bits[7:5], 2'b00, bits[4:3], bits[2:0]};
  endfunction

  // -1 on a miss
  function automatic int find_way(input logic [ADDR_BITS-1:0] addr);
    int found;
    found = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[set_of(addr)][w] && m_tag[set_of(addr)][w] == tag_of(addr)) begin
        found = w;
      end
    end
    return found;
  endfunction

  function automatic int victim_of(input logic [SET_BITS-1:0] s);
    if (!m_a[s]) begin
      return m_b[s] ? 1 : 0;
    end
    return m_c[s] ? 3 : 2;
  endfunction

  task automatic flag_mismatch(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_outputs();
    int                   rw;
    int                   vw;
    logic [SET_BITS-1:0]  vs;
    logic                 exp_hit;
    logic [LINE_BITS-1:0] exp_data;
    rw       = find_way(rd_addr);
    vs       = set_of(wr_addr);
    vw       = victim_of(vs);
    exp_hit  = rd_search && rw >= 0;
    exp_data = '0;
    if (exp_hit) begin
      exp_data = m_data[set_of(rd_addr)][rw];
    end
    assert (rd_hit === exp_hit)
      else flag_mismatch($sformatf("rd_hit %b, expected %b", rd_hit, exp_hit));
    assert (rd_data === exp_data)
      else flag_mismatch($sformatf("rd_data %h, expected %h", rd_data, exp_data));
    assert (wr_hit === (wr_search && find_way(wr_addr) >= 0))
      else flag_mismatch($sformatf("wr_hit %b for address %h", wr_hit, wr_addr));
    assert (evicted_valid === m_valid[vs][vw] && evicted_dirty === m_dirty[vs][vw])
      else flag_mismatch($sformatf("victim flags wrong in set %0d way %0d", vs, vw));
    if (m_valid[vs][vw]) begin
      assert (evicted_addr === {m_tag[vs][vw], vs, {OFFSET_BITS{1'b0}}})
        else flag_mismatch($sformatf("evicted_addr %h wrong", evicted_addr));
      assert (evicted_data === m_data[vs][vw])
        else flag_mismatch($sformatf("evicted_data %h wrong", evicted_data));
    end
  endtask

  // the write presented now lands at the next rising edge
  task automatic update_model();
    int                  w;
    logic [SET_BITS-1:0] s;
    s = set_of(wr_addr);
    w = find_way(wr_addr);
    if (wr_en && (w >= 0 || wr_from_mem)) begin
      if (w < 0) begin
        w = victim_of(s);
        if (!m_a[s]) begin
          m_b[s] = !m_b[s];
        end else begin
          m_c[s] = !m_c[s];
        end
        m_a[s] = !m_a[s];
      end
      m_tag[s][w]   = tag_of(wr_addr);
      m_data[s][w]  = wr_data;
      m_valid[s][w] = wr_valid;
      m_dirty[s][w] = wr_dirty;
    end
  endtask

  task automatic apply_cycle(input logic [ADDR_BITS-1:0] ra, input logic rs,
                             input logic we, input logic wm, input logic ws,
                             input logic [ADDR_BITS-1:0] wa,
                             input logic [LINE_BITS-1:0] wd,
                             input logic wv, input logic wdt);
    @(posedge clock);
    rd_addr     <= ra;
    rd_search   <= rs;
    wr_en       <= we;
    wr_from_mem <= wm;
    wr_search   <= ws;
    wr_addr     <= wa;
    wr_data     <= wd;
    wr_valid    <= wv;
    wr_dirty    <= wdt;
    // combinational outputs have settled by the falling edge
    @(negedge clock);
    check_outputs();
    update_model();
  endtask

  task automatic fill_line(input logic [ADDR_BITS-1:0] addr, input logic [LINE_BITS-1:0] data);
    apply_cycle(addr, 1'b1, 1'b1, 1'b1, 1'b1, addr, data, 1'b1, 1'b0);
  endtask

  task automatic store_line(input logic [ADDR_BITS-1:0] addr,
                            input logic [LINE_BITS-1:0] data, input logic dirty);
    apply_cycle(addr, 1'b1, 1'b1, 1'b0, 1'b1, addr, data, 1'b1, dirty);
  endtask

  task automatic read_line(input logic [ADDR_BITS-1:0] addr, input logic search);
    apply_cycle(addr, search, 1'b0, 1'b0, 1'b1, addr, '0, 1'b0, 1'b0);
  endtask

  task automatic wait_for_idle(output logic ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < 20) begin
      @(negedge clock);
      ok = !rd_hit && !wr_hit && !evicted_valid;
      cycles++;
    end
  endtask

  initial begin
    logic [ADDR_BITS-1:0] a0;
    logic [ADDR_BITS-1:0] set5 [5];
    logic [LINE_BITS-1:0] d1;
    logic [LINE_BITS-1:0] fill_data [5];
    logic [31:0]          r1;
    logic [31:0]          r2;
    logic                 ok;
    int                   sva_fails;
    seed        = 32'h79e8_772a;
    errors      = 0;
    clock       = 1'b0;
    reset       <= 1'b1;
    rd_addr     <= '0;
    rd_search   <= 1'b0;
    wr_en       <= 1'b0;
    wr_from_mem <= 1'b0;
    wr_search   <= 1'b0;
    wr_addr     <= '0;
    wr_data     <= '0;
    wr_valid    <= 1'b0;
    wr_dirty    <= 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_a[s] = 1'b0;
      m_b[s] = 1'b0;
      m_c[s] = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w]   = '0;
        m_data[s][w]  = '0;
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
      end
    end
    repeat (16) @(posedge clock);
    reset     <= 1'b0;
    rd_search <= 1'b1;
    wr_search <= 1'b1;
    wait_for_idle(ok);
    if (!ok) begin
      $display("Timeout: cache outputs did not clear within 20 cycles after reset");
      $display("Errors found");
    end else begin
      for (int s = 0; s < NUM_SETS; s++) begin
        read_line(line_addr(TAG_BITS'(s), SET_BITS'(s)), 1'b1);
        assert (!rd_hit && !wr_hit && !evicted_valid)
          else flag_mismatch($sformatf("set %0d not empty after reset", s));
      end
      // fill then read back with and without the search strobe
      a0 = line_addr(25'h0_1234, 4'd1);
      fill_data[0] = {$random(seed), $random(seed)};
      fill_line(a0, fill_data[0]);
      read_line(a0 | 32'd5, 1'b1);
      assert (rd_hit && rd_data === fill_data[0])
        else flag_mismatch("fill not visible in the next cycle");
      read_line(a0, 1'b0);
      assert (!rd_hit) else flag_mismatch("rd_hit high without rd_search");
      d1 = {$random(seed), $random(seed)};
      store_line(a0, d1, 1'b1);
      assert (wr_hit) else flag_mismatch("store to a present line missed");
      // next fills go to ways 2, 1 and 3 and leave way 0 as victim
      for (int i = 0; i < 3; i++) begin
        fill_line(line_addr(TAG_BITS'(32'h200 + i), 4'd1), {$random(seed), $random(seed)});
      end
      read_line(a0, 1'b1);
      assert (rd_data === d1 && evicted_valid && evicted_dirty && evicted_addr === a0)
        else flag_mismatch("stored line not reported dirty as victim");
      store_line(line_addr(25'h0_0777, 4'd1), {$random(seed), $random(seed)}, 1'b1);
      read_line(line_addr(25'h0_0777, 4'd1), 1'b1);
      assert (!rd_hit && evicted_valid && evicted_addr === a0 && evicted_data === d1
              && evicted_dirty)
        else flag_mismatch("store miss changed the cache");
      // five fills into set 5
      for (int i = 0; i < 5; i++) begin
        set5[i]      = line_addr(TAG_BITS'(32'h300 + i), 4'd5);
        fill_data[i] = {$random(seed), $random(seed)};
      end
      for (int i = 0; i < 4; i++) begin
        fill_line(set5[i], fill_data[i]);
      end
      read_line(set5[0], 1'b1);
      assert (evicted_valid && evicted_addr === set5[0] && evicted_data === fill_data[0])
        else flag_mismatch("first fill is not the victim after four fills");
      fill_line(set5[4], fill_data[4]);
      read_line(set5[0], 1'b1);
      assert (!rd_hit) else flag_mismatch("evicted line still hits");
      for (int i = 0; i < 400; i++) begin
        r1 = $random(seed);
        r2 = $random(seed);
        apply_cycle(small_addr(r1[7:0]), r2[0] | r2[1], r2[2], r2[3] | r2[4], r2[5] | r2[6],
                    small_addr(r1[15:8]), {$random(seed), $random(seed)}, r2[7] | r2[8],
                    r2[9]);
      end
      sva_fails = i_dut.i_sva.failures;
      $display("Checks done: %0d testbench errors, %0d assertion failures", errors, sva_fails);
      if (errors == 0 && sva_fails == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
    end
    $finish;
  end

endmodule
